// File: all.f
+incdir+verilog
verilog/ballGamePkg.sv
verilog/ballHitIf.sv
verilog/flipperMotion.sv
verilog/ballController.sv
verilog/levelSequencer.sv
verilog/ballSubsystem.sv
test/ballSubsystemTb.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= ballSubsystemTb
FILELIST ?= all.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build products and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/ballSubsystemTb.sv
`include "ballGame_settings.svh"

module ballSubsystemTb
	import ballGamePkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int HOLD_CYCLES = 4; // even, so a missing axis lock cancels its own bounce.
localparam int FRAME_CYCLES = HOLD_CYCLES + 2;
localparam int NUM_FRAMES = 61;
localparam int TIMEOUT_NS = (8 + NUM_FRAMES * FRAME_CYCLES) * 20 + 2000;

logic clk;
logic resetN;
logic startOfFrame;
logic pause;
position_t flipperX;
ballVec_t borderTop;
ballVec_t borderLeft;
ballVec_t borderRight;
ballVec_t flipper;
ballVec_t obstacle;
hitEdge_t [`NUM_BALLS-1:0] hitEdge;
position_t ballX [`NUM_BALLS];
position_t ballY [`NUM_BALLS];
level_t level;
score_t score;

logic [31:0] lfsr = 32'hcc22;
event frameDone;

// reference model state, one entry per ball.
speed_t mSpeedX [`NUM_BALLS];
speed_t mSpeedY [`NUM_BALLS];
speed_t mPosX [`NUM_BALLS];
speed_t mPosY [`NUM_BALLS];
logic mLockX [`NUM_BALLS];
logic mLockY [`NUM_BALLS];
logic mBrickX [`NUM_BALLS];
logic mBrickY [`NUM_BALLS];
logic mBrickInFrame [`NUM_BALLS];
logic mHit [`NUM_BALLS];
position_t mPrevX;
logic mPrevValid;
speed_t mFlipSpeed;
logic mAdvance;
int mHitCount;
score_t mScore;
level_t mLevel;
logic mLevelReset;

ballSubsystem u_dut (.*);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

initial begin
	#(TIMEOUT_NS);
	$display("ERROR: the test timed out before all frames were checked");
	$display("TEST RESULT: FAIL");
	$fatal(1);
end

function automatic logic [31:0] randBits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1); // one step per bit.
	end
	return r;
endfunction

function automatic void resetBall(input int b, input level_t lvl);
	mPosX[b] = speed_t'((`INITIAL_X + `BALL_SPACING * b) * `FIXED_SCALE);
	mPosY[b] = speed_t'(`INITIAL_Y * `FIXED_SCALE);
	mSpeedX[b] = '0;
	mSpeedY[b] = speed_t'(`INITIAL_Y_SPEED) * (speed_t'(lvl) + 1);
	mLockX[b] = 1'b0;
	mLockY[b] = 1'b0;
	mBrickX[b] = 1'b0;
	mBrickY[b] = 1'b0;
	mBrickInFrame[b] = 1'b0;
	mHit[b] = 1'b0;
endfunction

// advances the model by one clock edge with the inputs now applied.
function automatic void stepModel();
	speed_t oSpeedX [`NUM_BALLS];
	speed_t oSpeedY [`NUM_BALLS];
	logic oBrickX [`NUM_BALLS];
	logic oBrickY [`NUM_BALLS];
	logic oHit [`NUM_BALLS];
	speed_t oFlipSpeed;
	logic oLevelReset;
	level_t oLevel;
	int hitsNow;
	logic rising;
	logic falling;
	logic movingLeft;
	logic movingRight;
	logic catchIt;
	oSpeedX = mSpeedX;
	oSpeedY = mSpeedY;
	oBrickX = mBrickX;
	oBrickY = mBrickY;
	oHit = mHit;
	oFlipSpeed = mFlipSpeed;
	oLevelReset = mLevelReset;
	oLevel = mLevel;
	hitsNow = 0;
	for (int b = 0; b < `NUM_BALLS; b++)
		if (oHit[b])
			hitsNow++;

	mScore = mScore + score_t'(hitsNow);
	mLevelReset = 1'b0;
	if (!mAdvance) begin
		mHitCount += hitsNow;
		if (mHitCount >= `BRICKS_PER_LEVEL)
			mAdvance = 1'b1;
	end else begin
		mHitCount = 0;
		mLevelReset = 1'b1;
		mLevel = (mLevel == level_t'(`MAX_LEVEL)) ? level_t'(0) : mLevel + 1'b1;
		mAdvance = 1'b0;
	end

	if (startOfFrame) begin // the flipper keeps measuring even during pause.
		mFlipSpeed = mPrevValid ?
			(speed_t'(flipperX) - speed_t'(mPrevX)) * `FLIPPER_GAIN : speed_t'(0);
		mPrevX = flipperX;
		mPrevValid = 1'b1;
	end

	for (int b = 0; b < `NUM_BALLS; b++) begin
		if (oLevelReset) begin
			resetBall(b, oLevel);
		end else begin
			mHit[b] = 1'b0;
			if (!pause) begin
				rising = oSpeedY[b] < 0;
				falling = oSpeedY[b] > 0;
				movingLeft = oSpeedX[b] < 0;
				movingRight = oSpeedX[b] > 0;
				catchIt = flipper[b] && falling;
				if (!mLockY[b]) begin
					if ((borderTop[b] && rising) || catchIt) begin
						mSpeedY[b] = -oSpeedY[b];
						mLockY[b] = 1'b1;
					end else if (obstacle[b] && ((hitEdge[b].top && rising) ||
							(hitEdge[b].bottom && falling))) begin
						mSpeedY[b] = -oSpeedY[b];
						mLockY[b] = 1'b1;
						mBrickY[b] = 1'b1;
					end
				end
				if (!mLockX[b]) begin
					if ((borderLeft[b] && movingLeft) || (borderRight[b] && movingRight)) begin
						mSpeedX[b] = -oSpeedX[b];
						mLockX[b] = 1'b1;
					end else if (obstacle[b] && ((hitEdge[b].left && movingLeft) ||
							(hitEdge[b].right && movingRight))) begin
						mSpeedX[b] = -oSpeedX[b];
						mLockX[b] = 1'b1;
						mBrickX[b] = 1'b1;
					end else if (catchIt) begin
						mSpeedX[b] = oSpeedX[b] + oFlipSpeed;
						mLockX[b] = 1'b1;
					end
				end
				if (!mBrickInFrame[b] && (oBrickX[b] || oBrickY[b])) begin
					mHit[b] = 1'b1;
					mBrickInFrame[b] = !startOfFrame;
				end else if (startOfFrame) begin
					mBrickInFrame[b] = 1'b0;
				end
				if (startOfFrame) begin
					mPosX[b] = mPosX[b] + oSpeedX[b];
					mPosY[b] = mPosY[b] + oSpeedY[b];
					mLockX[b] = 1'b0;
					mLockY[b] = 1'b0;
					mBrickX[b] = 1'b0;
					mBrickY[b] = 1'b0;
				end
			end
		end
	end
endfunction

task automatic checkPosition(input string what, input position_t got, input position_t exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end
endtask

task automatic checkLevel(input level_t got, input level_t exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t ns: level is %0d, expected %0d", $time, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end
endtask

task automatic checkScore(input score_t got, input score_t exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t ns: score is %0d, expected %0d", $time, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end
endtask

initial begin
	forever begin
		@(frameDone);
		for (int b = 0; b < `NUM_BALLS; b++) begin
			checkPosition($sformatf("ball %0d x", b), ballX[b],
				position_t'(mPosX[b] / `FIXED_SCALE));
			checkPosition($sformatf("ball %0d y", b), ballY[b],
				position_t'(mPosY[b] / `FIXED_SCALE));
		end
		checkLevel(level, mLevel);
		checkScore(score, mScore);
	end
end

// DUT samples at the rising edge, the model follows at the falling edge.
task automatic cycle();
	@(posedge clk);
	@(negedge clk);
	stepModel();
endtask

task automatic clearHits();
	borderTop = '0;
	borderLeft = '0;
	borderRight = '0;
	flipper = '0;
	obstacle = '0;
	hitEdge = '0;
endtask

task automatic runFrame(input logic doPause, input bit randomHits, input bit allBricks);
	pause = doPause;
	flipperX = position_t'(300 + int'(randBits(5)) - 16);
	clearHits();
	for (int b = 0; b < `NUM_BALLS; b++) begin
		if (randomHits) begin
			borderTop[b] = randBits(3) == 0;
			borderLeft[b] = randBits(3) == 0;
			borderRight[b] = randBits(3) == 0;
			flipper[b] = randBits(2) == 0;
			obstacle[b] = randBits(2) == 0;
			hitEdge[b] = hitEdge_t'(randBits(4));
		end else if (allBricks) begin
			obstacle[b] = 1'b1;
			hitEdge[b] = hitEdge_t'(4'b1111); // any vertical motion takes the brick.
		end
	end
	repeat (HOLD_CYCLES) cycle();
	clearHits();
	cycle();
	startOfFrame = 1'b1;
	cycle();
	startOfFrame = 1'b0;
	->frameDone;
endtask

initial begin
	resetN = 1'b0;
	startOfFrame = 1'b0;
	pause = 1'b0;
	flipperX = position_t'(300);
	clearHits();
	mPrevX = '0;
	mPrevValid = 1'b0;
	mFlipSpeed = '0;
	mAdvance = 1'b0;
	mHitCount = 0;
	mScore = '0;
	mLevel = '0;
	mLevelReset = 1'b0;
	for (int b = 0; b < `NUM_BALLS; b++)
		resetBall(b, '0);
	repeat (8) @(negedge clk);
	resetN = 1'b1;

	repeat (4) runFrame(1'b0, 1'b0, 1'b0);
	repeat (40) runFrame(1'b0, 1'b1, 1'b0);
	repeat (4) runFrame(1'b1, 1'b1, 1'b0);
	repeat (3) runFrame(1'b0, 1'b0, 1'b1);
	repeat (10) runFrame(1'b0, 1'b1, 1'b0);

	repeat (2) @(negedge clk);
	$display("TEST RESULT: PASS");
	$finish;
end

endmodule

// File: verilog/ballSubsystem.sv
`include "ballGame_settings.svh"

module ballSubsystem
	import ballGamePkg::*;
(
	input	logic						clk,
	input	logic						resetN,
	input	logic						startOfFrame,
	input	logic						pause,
	input	position_t					flipperX,
	input	ballVec_t					borderTop,
	input	ballVec_t					borderLeft,
	input	ballVec_t					borderRight,
	input	ballVec_t					flipper,
	input	ballVec_t					obstacle,
	input	hitEdge_t [`NUM_BALLS-1:0]	hitEdge,
	output	position_t					ballX [`NUM_BALLS],
	output	position_t					ballY [`NUM_BALLS],
	output	level_t						level,
	output	score_t						score
);

ballHitIf hits [`NUM_BALLS] ();

ballVec_t obstacleHit;
logic levelReset;

flipperMotion motionUnit (
	.clk			(clk),
	.resetN			(resetN),
	.startOfFrame	(startOfFrame),
	.flipperX		(flipperX),
	.borderTop		(borderTop),
	.borderLeft		(borderLeft),
	.borderRight	(borderRight),
	.flipper		(flipper),
	.obstacle		(obstacle),
	.hitEdge		(hitEdge),
	.hits			(hits)
);

genvar i;
generate
	for (i = 0; i < `NUM_BALLS; i++) begin : balls
		ballController #(
			.BALL_INDEX	(i)
		) ballUnit (
			.clk			(clk),
			.resetN			(resetN),
			.startOfFrame	(startOfFrame),
			.pause			(pause),
			.levelReset		(levelReset),
			.level			(level),
			.hit			(hits[i]),
			.topLeftX		(ballX[i]),
			.topLeftY		(ballY[i]),
			.obstacleHit	(obstacleHit[i])
		);
	end
endgenerate

levelSequencer sequencer (
	.clk			(clk),
	.resetN			(resetN),
	.obstacleHit	(obstacleHit),
	.level			(level),
	.score			(score),
	.levelReset		(levelReset)
);

endmodule

// File: verilog/levelSequencer.sv
`include "ballGame_settings.svh"

module levelSequencer
	import ballGamePkg::*;
(
	input	logic		clk,
	input	logic		resetN,
	input	ballVec_t	obstacleHit,
	output	level_t		level,
	output	score_t		score,
	output	logic		levelReset
);

// wide enough for a full level plus one cycle of hits from every ball.
localparam int COUNT_W = $clog2(`BRICKS_PER_LEVEL + `NUM_BALLS + 1);

levelState_t state;

logic [COUNT_W-1:0] hitCount;
logic [COUNT_W-1:0] hitsNow;
logic [COUNT_W-1:0] nextCount;

always_comb begin
	hitsNow = '0;
	for (int i = 0; i < `NUM_BALLS; i++)
		hitsNow = hitsNow + COUNT_W'(obstacleHit[i]);
end

assign nextCount = hitCount + hitsNow;

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		state <= PLAYING;
		hitCount <= '0;
		score <= '0;
		level <= '0;
		levelReset <= 1'b0;
	end
	else begin
		score <= score + score_t'(hitsNow); // every hit scores, even while advancing.
		levelReset <= 1'b0;

		case (state)
			PLAYING: begin
				hitCount <= nextCount;
				if (nextCount >= COUNT_W'(`BRICKS_PER_LEVEL))
					state <= ADVANCE;
			end

			ADVANCE: begin
				hitCount <= '0;
				levelReset <= 1'b1;
				if (level == level_t'(`MAX_LEVEL))
					level <= '0;
				else
					level <= level + level_t'(1);
				state <= PLAYING;
			end

			default: state <= PLAYING;
		endcase
	end
end

endmodule

// File: verilog/ballController.sv
`include "ballGame_settings.svh"

module ballController
	import ballGamePkg::*;
#(
	parameter int BALL_INDEX = 0
)(
	input	logic		clk,
	input	logic		resetN,
	input	logic		startOfFrame,
	input	logic		pause,
	input	logic		levelReset,
	input	level_t		level,
	ballHitIf.sink		hit,
	output	position_t	topLeftX,
	output	position_t	topLeftY,
	output	logic		obstacleHit
);

localparam speed_t START_X =
	speed_t'((`INITIAL_X + `BALL_SPACING * BALL_INDEX) * `FIXED_SCALE);
localparam speed_t START_Y = speed_t'(`INITIAL_Y * `FIXED_SCALE);

speed_t speedX;
speed_t speedY;
speed_t posX; // fixed point, 1/64 pixel.
speed_t posY;

logic lockX; // axis already bounced in this frame.
logic lockY;

logic brickX; // the axis bounced off a brick in this frame.
logic brickY;
logic brickInFrame;

logic rising;
logic falling;
logic movingLeft;
logic movingRight;
logic flipperCatch;
logic bounceY;
logic brickBounceY;
logic bounceX;
logic brickBounceX;

assign rising = (speedY < 0);
assign falling = (speedY > 0);
assign movingLeft = (speedX < 0);
assign movingRight = (speedX > 0);

assign flipperCatch = hit.flipper && falling; // a rising ball passes the flipper untouched.

assign bounceY = (hit.borderTop && rising) || flipperCatch;
assign brickBounceY = hit.obstacle &&
	((hit.hitEdge.top && rising) || (hit.hitEdge.bottom && falling));

assign bounceX = (hit.borderLeft && movingLeft) || (hit.borderRight && movingRight);
assign brickBounceX = hit.obstacle &&
	((hit.hitEdge.left && movingLeft) || (hit.hitEdge.right && movingRight));

// vertical axis.
always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		speedY <= speed_t'(`INITIAL_Y_SPEED);
		posY <= START_Y;
		lockY <= 1'b0;
		brickY <= 1'b0;
	end
	else if (levelReset) begin
		speedY <= speed_t'(`INITIAL_Y_SPEED) * (speed_t'(level) + speed_t'(1));
		posY <= START_Y;
		lockY <= 1'b0;
		brickY <= 1'b0;
	end
	else if (!pause) begin
		if (!lockY) begin
			if (bounceY) begin
				speedY <= -speedY;
				lockY <= 1'b1;
			end
			else if (brickBounceY) begin
				speedY <= -speedY;
				lockY <= 1'b1;
				brickY <= 1'b1;
			end
		end

		// the step uses the speed from before this edge.
		if (startOfFrame) begin
			posY <= posY + speedY;
			lockY <= 1'b0;
			brickY <= 1'b0;
		end
	end
end

// horizontal axis.
always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		speedX <= '0;
		posX <= START_X;
		lockX <= 1'b0;
		brickX <= 1'b0;
	end
	else if (levelReset) begin
		speedX <= '0;
		posX <= START_X;
		lockX <= 1'b0;
		brickX <= 1'b0;
	end
	else if (!pause) begin
		if (!lockX) begin
			if (bounceX) begin
				speedX <= -speedX;
				lockX <= 1'b1;
			end
			else if (brickBounceX) begin
				speedX <= -speedX;
				lockX <= 1'b1;
				brickX <= 1'b1;
			end
			else if (flipperCatch) begin
				speedX <= speedX + hit.flipperSpeedX; // the ball inherits the flipper's motion.
				lockX <= 1'b1;
			end
		end

		if (startOfFrame) begin
			posX <= posX + speedX;
			lockX <= 1'b0;
			brickX <= 1'b0;
		end
	end
end

// one obstacleHit pulse per frame, whichever axis took the brick.
always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		obstacleHit <= 1'b0;
		brickInFrame <= 1'b0;
	end
	else if (levelReset) begin
		obstacleHit <= 1'b0;
		brickInFrame <= 1'b0;
	end
	else begin
		obstacleHit <= 1'b0;
		if (!pause) begin
			if (startOfFrame)
				brickInFrame <= 1'b0;

			if (!brickInFrame && (brickX || brickY)) begin
				obstacleHit <= 1'b1;
				// at a frame edge the brick flags clear too, so the new frame starts open.
				brickInFrame <= !startOfFrame;
			end
		end
	end
end

assign topLeftX = position_t'(posX / `FIXED_SCALE);
assign topLeftY = position_t'(posY / `FIXED_SCALE);

endmodule

// File: verilog/flipperMotion.sv
`include "ballGame_settings.svh"

module flipperMotion
	import ballGamePkg::*;
(
	input	logic						clk,
	input	logic						resetN,
	input	logic						startOfFrame,
	input	position_t					flipperX,
	input	ballVec_t					borderTop,
	input	ballVec_t					borderLeft,
	input	ballVec_t					borderRight,
	input	ballVec_t					flipper,
	input	ballVec_t					obstacle,
	input	hitEdge_t [`NUM_BALLS-1:0]	hitEdge,
	ballHitIf.source					hits [`NUM_BALLS]
);

position_t prevX;
logic prevValid; // no speed until one frame position has been seen.
speed_t flipperSpeed;
speed_t deltaX;

assign deltaX = speed_t'(flipperX) - speed_t'(prevX);

always_ff @(posedge clk) begin
	if (startOfFrame)
		prevX <= flipperX;
end

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		prevValid <= 1'b0;
		flipperSpeed <= '0;
	end
	else if (startOfFrame) begin
		prevValid <= 1'b1;
		if (prevValid)
			flipperSpeed <= deltaX * speed_t'(`FLIPPER_GAIN);
		else
			flipperSpeed <= '0;
	end
end

// collision flags go straight through to each ball.
genvar i;
generate
	for (i = 0; i < `NUM_BALLS; i++) begin : fanOut
		assign hits[i].borderTop = borderTop[i];
		assign hits[i].borderLeft = borderLeft[i];
		assign hits[i].borderRight = borderRight[i];
		assign hits[i].flipper = flipper[i];
		assign hits[i].obstacle = obstacle[i];
		assign hits[i].hitEdge = hitEdge[i];
		assign hits[i].flipperSpeedX = flipperSpeed;
	end
endgenerate

endmodule

// File: verilog/ballHitIf.sv
interface ballHitIf
	import ballGamePkg::*;
();

	logic		borderTop;
	logic		borderLeft;
	logic		borderRight;
	logic		flipper;
	logic		obstacle;
	hitEdge_t	hitEdge; // only meaningful while obstacle is high.
	speed_t		flipperSpeedX;

	modport source (
		output borderTop,
		output borderLeft,
		output borderRight,
		output flipper,
		output obstacle,
		output hitEdge,
		output flipperSpeedX
	);

	modport sink (
		input borderTop,
		input borderLeft,
		input borderRight,
		input flipper,
		input obstacle,
		input hitEdge,
		input flipperSpeedX
	);

endinterface

// File: verilog/ballGamePkg.sv
`include "ballGame_settings.svh"

package ballGamePkg;

	typedef logic signed [10:0] position_t; // screen coordinate in pixels.
	typedef logic signed [31:0] speed_t; // 1/64 pixel per frame, also the fixed-point position.
	typedef logic [3:0] level_t;
	typedef logic [15:0] score_t;

	// one flag per ball.
	typedef logic [`NUM_BALLS-1:0] ballVec_t;

	// which edge of a brick the ball touched.
	typedef struct packed {
		logic left;
		logic top;
		logic right;
		logic bottom;
	} hitEdge_t;

	typedef enum logic {
		PLAYING,
		ADVANCE
	} levelState_t;

endpackage

// File: verilog/ballGame_settings.svh
`ifndef BALLGAME_SETTINGS_SVH
`define BALLGAME_SETTINGS_SVH

// number of balls on the screen at once.
`define NUM_BALLS 3

// positions and speeds are kept in 1/64 pixel units.
`define FIXED_SCALE 64

// start corner of ball 0, in pixels. Ball k starts BALL_SPACING*k pixels further right.
`define INITIAL_X 100
`define INITIAL_Y 50
`define BALL_SPACING 60

`define INITIAL_Y_SPEED 100 // fall speed at level 0, 1/64 pixel per frame.

`define FLIPPER_GAIN 16 // flipper pixels per frame to ball speed units.

`define BRICKS_PER_LEVEL 8
`define MAX_LEVEL 9 // the level wraps to 0 after this one.

`endif
